//--- hw/riscv_defs.svh
`ifndef RISCV_DEFS_SVH
`define RISCV_DEFS_SVH

`define RV_XLEN     32
`define RV_NREGS    32
`define RV_RESET_PC 32'h0000_0000

// major opcodes including the low two bits
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011
`define RV_OP_SYSTEM 7'b1110011

// alu funct3
`define RV_F3_ADD  3'b000
`define RV_F3_SLL  3'b001
`define RV_F3_SLT  3'b010
`define RV_F3_SLTU 3'b011
`define RV_F3_XOR  3'b100
`define RV_F3_SR   3'b101
`define RV_F3_OR   3'b110
`define RV_F3_AND  3'b111

// branch funct3
`define RV_F3_BEQ  3'b000
`define RV_F3_BNE  3'b001
`define RV_F3_BLT  3'b100
`define RV_F3_BGE  3'b101
`define RV_F3_BLTU 3'b110
`define RV_F3_BGEU 3'b111

`endif

//--- hw/riscv_pkg.sv
`default_nettype none

`include "riscv_defs.svh"

package riscv_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [$clog2(`RV_NREGS)-1:0] reg_addr_t;
  typedef logic [`RV_XLEN/8-1:0] strb_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_t;

  typedef enum logic [2:0] {
    class_alu, class_branch, class_jal, class_jalr,
    class_load, class_store, class_auipc, class_illegal
  } instr_class_t;

  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } mem_size_t;

  typedef enum logic [2:0] {
    st_fetch, st_fetch_wait, st_decode, st_execute,
    st_mem_wait, st_check_pc, st_reg_write, st_trapped
  } cpu_state_t;

  typedef struct packed {
    instr_class_t cls;
    alu_op_t      alu_op;
    logic         b_is_imm;
    word_t        imm;
    reg_addr_t    rd;
    reg_addr_t    rs1;
    reg_addr_t    rs2;
    logic [2:0]   funct3;
    mem_size_t    mem_size;
    logic         load_unsigned;
    logic         write_rd;
  } decoded_t;

  typedef struct packed {
    word_t result;
    word_t next_pc;
    word_t mem_addr;
    logic  misaligned;
    logic  take_branch;
  } exec_t;

  typedef struct packed {
    word_t addr;
    word_t wdata;
    strb_t strb;
    logic  instr;
  } mem_req_t;

endpackage

`default_nettype wire

//--- hw/riscv_decoder.sv
`default_nettype none

`include "riscv_defs.svh"

module riscv_decoder (
  input  wire riscv_pkg::word_t instr,
  output riscv_pkg::decoded_t   dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  riscv_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;

  function automatic riscv_pkg::alu_op_t alu_op_of(input logic [2:0] f3, input logic alt);
    riscv_pkg::alu_op_t op;
    case (f3)
      `RV_F3_ADD:  op = alt ? riscv_pkg::alu_sub : riscv_pkg::alu_add;
      `RV_F3_SLL:  op = riscv_pkg::alu_sll;
      `RV_F3_SLT:  op = riscv_pkg::alu_slt;
      `RV_F3_SLTU: op = riscv_pkg::alu_sltu;
      `RV_F3_XOR:  op = riscv_pkg::alu_xor;
      `RV_F3_SR:   op = alt ? riscv_pkg::alu_sra : riscv_pkg::alu_srl;
      `RV_F3_OR:   op = riscv_pkg::alu_or;
      default:     op = riscv_pkg::alu_and;
    endcase
    return op;
  endfunction

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    dec = '0;
    dec.cls = riscv_pkg::class_illegal;
    dec.alu_op = riscv_pkg::alu_add;
    dec.rd = instr[11:7];
    dec.rs1 = instr[19:15];
    dec.rs2 = instr[24:20];
    dec.funct3 = funct3;
    dec.load_unsigned = funct3[2];
    case (funct3[1:0])
      2'b00:   dec.mem_size = riscv_pkg::size_byte;
      2'b01:   dec.mem_size = riscv_pkg::size_half;
      default: dec.mem_size = riscv_pkg::size_word;
    endcase

    case (opcode)
      `RV_OP_LUI: begin
        dec.cls = riscv_pkg::class_alu;
        dec.alu_op = riscv_pkg::alu_pass_b;
        dec.b_is_imm = 1'b1;
        dec.imm = imm_u;
      end
      `RV_OP_AUIPC: begin
        dec.cls = riscv_pkg::class_auipc;
        dec.b_is_imm = 1'b1;
        dec.imm = imm_u;
      end
      `RV_OP_JAL: begin
        dec.cls = riscv_pkg::class_jal;
        dec.imm = imm_j;
      end
      `RV_OP_JALR: begin
        if (funct3 == 3'b000) dec.cls = riscv_pkg::class_jalr;
        dec.imm = imm_i;
      end
      `RV_OP_BRANCH: begin
        if (funct3[2:1] != 2'b01) dec.cls = riscv_pkg::class_branch;
        dec.imm = imm_b;
      end
      `RV_OP_LOAD: begin
        // lb lh lw lbu lhu only
        if (funct3[1:0] != 2'b11 && funct3 != 3'b110) dec.cls = riscv_pkg::class_load;
        dec.imm = imm_i;
      end
      `RV_OP_STORE: begin
        if (!funct3[2] && funct3[1:0] != 2'b11) dec.cls = riscv_pkg::class_store;
        dec.imm = imm_s;
      end
      `RV_OP_IMM: begin
        dec.b_is_imm = 1'b1;
        dec.imm = imm_i;
        // shift immediates carry funct7 in the upper imm bits
        if ((funct3 != `RV_F3_SLL && funct3 != `RV_F3_SR) || funct7 == 7'h00 ||
            (funct3 == `RV_F3_SR && funct7 == 7'h20)) begin
          dec.cls = riscv_pkg::class_alu;
          dec.alu_op = alu_op_of(funct3, funct3 == `RV_F3_SR && funct7[5]);
        end
      end
      `RV_OP_REG: begin
        if (funct7 == 7'h00 ||
            (funct7 == 7'h20 && (funct3 == `RV_F3_ADD || funct3 == `RV_F3_SR))) begin
          dec.cls = riscv_pkg::class_alu;
          dec.alu_op = alu_op_of(funct3, funct7[5]);
        end
      end
      // ecall and ebreak stop the core
      `RV_OP_SYSTEM: dec.cls = riscv_pkg::class_illegal;
      default:       dec.cls = riscv_pkg::class_illegal;
    endcase

    dec.write_rd = (instr[11:7] != 5'd0) &&
                   (dec.cls == riscv_pkg::class_alu || dec.cls == riscv_pkg::class_auipc ||
                    dec.cls == riscv_pkg::class_jal || dec.cls == riscv_pkg::class_jalr ||
                    dec.cls == riscv_pkg::class_load);
  end

endmodule

`default_nettype wire

//--- hw/riscv_regfile.sv
`default_nettype none

`include "riscv_defs.svh"

module riscv_regfile (
  input  wire                     clk,
  input  wire                     reset,
  input  wire riscv_pkg::reg_addr_t rs1,
  input  wire riscv_pkg::reg_addr_t rs2,
  output riscv_pkg::word_t          rs1_data,
  output riscv_pkg::word_t          rs2_data,
  input  wire                     we,
  input  wire riscv_pkg::reg_addr_t rd,
  input  wire riscv_pkg::word_t     rd_data
);

  riscv_pkg::word_t regs [`RV_NREGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // x0 hardwired
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- hw/riscv_execute.sv
`default_nettype none

`include "riscv_defs.svh"

module riscv_execute (
  input  wire riscv_pkg::decoded_t dec,
  input  wire riscv_pkg::word_t    pc,
  input  wire riscv_pkg::word_t    rs1_data,
  input  wire riscv_pkg::word_t    rs2_data,
  output riscv_pkg::exec_t         ex
);

  riscv_pkg::word_t op_a, op_b, alu_out, pc_plus4, target;
  logic [4:0] shamt;
  logic       is_jump, cond;

  // auipc reuses the adder with pc as operand a
  assign op_a = (dec.cls == riscv_pkg::class_auipc) ? pc : rs1_data;
  assign op_b = dec.b_is_imm ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec.alu_op)
      riscv_pkg::alu_add:  alu_out = op_a + op_b;
      riscv_pkg::alu_sub:  alu_out = op_a - op_b;
      riscv_pkg::alu_sll:  alu_out = op_a << shamt;
      riscv_pkg::alu_slt:  alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      riscv_pkg::alu_sltu: alu_out = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
      riscv_pkg::alu_xor:  alu_out = op_a ^ op_b;
      riscv_pkg::alu_srl:  alu_out = op_a >> shamt;
      riscv_pkg::alu_sra:  alu_out = $signed(op_a) >>> shamt;
      riscv_pkg::alu_or:   alu_out = op_a | op_b;
      riscv_pkg::alu_and:  alu_out = op_a & op_b;
      default:             alu_out = op_b;
    endcase
  end

  always_comb begin
    case (dec.funct3)
      `RV_F3_BEQ:  cond = rs1_data == rs2_data;
      `RV_F3_BNE:  cond = rs1_data != rs2_data;
      `RV_F3_BLT:  cond = $signed(rs1_data) < $signed(rs2_data);
      `RV_F3_BGE:  cond = $signed(rs1_data) >= $signed(rs2_data);
      `RV_F3_BLTU: cond = rs1_data < rs2_data;
      `RV_F3_BGEU: cond = rs1_data >= rs2_data;
      default:     cond = 1'b0;
    endcase
  end

  assign is_jump = dec.cls == riscv_pkg::class_jal || dec.cls == riscv_pkg::class_jalr;
  assign pc_plus4 = pc + 32'd4;
  assign target = (dec.cls == riscv_pkg::class_jalr) ?
                  ((rs1_data + dec.imm) & ~32'd1) : (pc + dec.imm);

  always_comb begin
    ex.take_branch = is_jump || (dec.cls == riscv_pkg::class_branch && cond);
    ex.next_pc = ex.take_branch ? target : pc_plus4;
    // link value for jumps
    ex.result = is_jump ? pc_plus4 : alu_out;
    ex.mem_addr = rs1_data + dec.imm;
    ex.misaligned = 1'b0;
    if (dec.cls == riscv_pkg::class_load || dec.cls == riscv_pkg::class_store) begin
      case (dec.mem_size)
        riscv_pkg::size_half: ex.misaligned = ex.mem_addr[0];
        riscv_pkg::size_word: ex.misaligned = |ex.mem_addr[1:0];
        default:              ex.misaligned = 1'b0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/riscv_lsu.sv
`default_nettype none

module riscv_lsu (
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      fetch_start,
  input  wire riscv_pkg::word_t    fetch_addr,
  input  wire                      data_start,
  input  wire riscv_pkg::decoded_t dec,
  input  wire riscv_pkg::exec_t    ex,
  input  wire riscv_pkg::word_t    rs2_data,
  output logic                     done,
  output riscv_pkg::word_t         rdata,
  output logic                     mem_valid,
  output logic                     mem_instr,
  output riscv_pkg::word_t         mem_addr,
  output riscv_pkg::word_t         mem_wdata,
  output riscv_pkg::strb_t         mem_wstrb,
  input  wire                      mem_ready,
  input  wire riscv_pkg::word_t    mem_rdata
);

  riscv_pkg::mem_req_t req;
  riscv_pkg::word_t    store_data, lane;
  riscv_pkg::strb_t    store_strb;
  logic                valid;

  // replicate the store value over every lane
  always_comb begin
    case (dec.mem_size)
      riscv_pkg::size_byte: begin
        store_data = {4{rs2_data[7:0]}};
        store_strb = 4'b0001 << ex.mem_addr[1:0];
      end
      riscv_pkg::size_half: begin
        store_data = {2{rs2_data[15:0]}};
        store_strb = ex.mem_addr[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        store_data = rs2_data;
        store_strb = 4'b1111;
      end
    endcase
    if (dec.cls != riscv_pkg::class_store) store_strb = '0;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= 1'b0;
      req.strb <= '0;
    end else if (fetch_start) begin
      valid <= 1'b1;
      req <= '{addr: fetch_addr, wdata: '0, strb: '0, instr: 1'b1};
    end else if (data_start) begin
      valid <= 1'b1;
      req <= '{addr: {ex.mem_addr[31:2], 2'b00}, wdata: store_data, strb: store_strb,
               instr: 1'b0};
    end else if (valid && mem_ready) begin
      valid <= 1'b0;
    end
  end

  assign mem_valid = valid;
  assign mem_instr = req.instr;
  assign mem_addr = req.addr;
  assign mem_wdata = req.wdata;
  assign mem_wstrb = req.strb;
  assign done = valid && mem_ready;

  // selected lane moved down to bit 0
  assign lane = mem_rdata >> {ex.mem_addr[1:0], 3'b000};

  always_comb begin
    case (dec.mem_size)
      riscv_pkg::size_byte:
        rdata = dec.load_unsigned ? {24'b0, lane[7:0]} : {{24{lane[7]}}, lane[7:0]};
      riscv_pkg::size_half:
        rdata = dec.load_unsigned ? {16'b0, lane[15:0]} : {{16{lane[15]}}, lane[15:0]};
      default:
        rdata = mem_rdata;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/riscv_control.sv
`default_nettype none

`include "riscv_defs.svh"

module riscv_control (
  input  wire                      clk,
  input  wire                      reset,
  input  wire riscv_pkg::decoded_t dec,
  input  wire riscv_pkg::exec_t    ex,
  input  wire                      lsu_done,
  input  wire riscv_pkg::word_t    lsu_rdata,
  input  wire riscv_pkg::word_t    mem_rdata,
  output riscv_pkg::word_t         instr,
  output riscv_pkg::word_t         pc,
  output logic                     fetch_start,
  output riscv_pkg::word_t         fetch_addr,
  output logic                     data_start,
  output logic                     rf_we,
  output riscv_pkg::word_t         rf_wdata,
  output logic                     trap
);

  riscv_pkg::cpu_state_t state;
  riscv_pkg::word_t      next_pc;
  riscv_pkg::word_t      wb;
  logic                  is_mem;

  assign is_mem = dec.cls == riscv_pkg::class_load || dec.cls == riscv_pkg::class_store;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= riscv_pkg::st_fetch;
      next_pc <= `RV_RESET_PC;
      pc <= `RV_RESET_PC;
    end else begin
      case (state)
        riscv_pkg::st_fetch: state <= riscv_pkg::st_fetch_wait;
        riscv_pkg::st_fetch_wait: begin
          if (lsu_done) begin
            instr <= mem_rdata;
            pc <= next_pc;
            state <= riscv_pkg::st_decode;
          end
        end
        riscv_pkg::st_decode: state <= riscv_pkg::st_execute;
        riscv_pkg::st_execute: begin
          case (dec.cls)
            riscv_pkg::class_alu, riscv_pkg::class_auipc: begin
              wb <= ex.result;
              next_pc <= ex.next_pc;
              state <= riscv_pkg::st_reg_write;
            end
            riscv_pkg::class_jal, riscv_pkg::class_jalr, riscv_pkg::class_branch: begin
              wb <= ex.result;
              state <= riscv_pkg::st_check_pc;
            end
            riscv_pkg::class_load, riscv_pkg::class_store: begin
              if (ex.misaligned) begin
                state <= riscv_pkg::st_trapped;
              end else begin
                next_pc <= ex.next_pc;
                state <= riscv_pkg::st_mem_wait;
              end
            end
            default: state <= riscv_pkg::st_trapped;
          endcase
        end
        riscv_pkg::st_mem_wait: begin
          if (lsu_done) begin
            if (dec.cls == riscv_pkg::class_load) begin
              wb <= lsu_rdata;
              state <= riscv_pkg::st_reg_write;
            end else begin
              state <= riscv_pkg::st_fetch;
            end
          end
        end
        riscv_pkg::st_check_pc: begin
          // no compressed set, so both low bits must be clear
          if (ex.take_branch && |ex.next_pc[1:0]) begin
            state <= riscv_pkg::st_trapped;
          end else begin
            next_pc <= ex.next_pc;
            state <= (dec.cls == riscv_pkg::class_branch) ?
                     riscv_pkg::st_fetch : riscv_pkg::st_reg_write;
          end
        end
        riscv_pkg::st_reg_write: state <= riscv_pkg::st_fetch;
        default: state <= riscv_pkg::st_trapped;
      endcase
    end
  end

  assign fetch_start = state == riscv_pkg::st_fetch;
  assign fetch_addr = next_pc;
  assign data_start = state == riscv_pkg::st_execute && is_mem && !ex.misaligned;
  assign rf_we = state == riscv_pkg::st_reg_write && dec.write_rd;
  assign rf_wdata = wb;
  assign trap = state == riscv_pkg::st_trapped;

endmodule

`default_nettype wire

//--- hw/riscv_core.sv
`default_nettype none

module riscv_core (
  input  wire                   clk,
  input  wire                   reset,
  output logic                  mem_valid,
  output logic                  mem_instr,
  input  wire                   mem_ready,
  output riscv_pkg::word_t      mem_addr,
  output riscv_pkg::word_t      mem_wdata,
  output riscv_pkg::strb_t      mem_wstrb,
  input  wire riscv_pkg::word_t mem_rdata,
  output logic                  trap
);

  riscv_pkg::decoded_t dec;
  riscv_pkg::exec_t    ex;
  riscv_pkg::word_t    instr, pc, rs1_data, rs2_data;
  riscv_pkg::word_t    fetch_addr, lsu_rdata, rf_wdata;
  logic                fetch_start, data_start, lsu_done, rf_we;

  riscv_decoder riscv_decoder_i (
    .instr (instr),
    .dec   (dec)
  );

  riscv_regfile riscv_regfile_i (
    .clk      (clk),
    .reset    (reset),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (rf_we),
    .rd       (dec.rd),
    .rd_data  (rf_wdata)
  );

  riscv_execute riscv_execute_i (
    .dec      (dec),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .ex       (ex)
  );

  riscv_lsu riscv_lsu_i (
    .clk         (clk),
    .reset       (reset),
    .fetch_start (fetch_start),
    .fetch_addr  (fetch_addr),
    .data_start  (data_start),
    .dec         (dec),
    .ex          (ex),
    .rs2_data    (rs2_data),
    .done        (lsu_done),
    .rdata       (lsu_rdata),
    .mem_valid   (mem_valid),
    .mem_instr   (mem_instr),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_wstrb   (mem_wstrb),
    .mem_ready   (mem_ready),
    .mem_rdata   (mem_rdata)
  );

  riscv_control riscv_control_i (
    .clk         (clk),
    .reset       (reset),
    .dec         (dec),
    .ex          (ex),
    .lsu_done    (lsu_done),
    .lsu_rdata   (lsu_rdata),
    .mem_rdata   (mem_rdata),
    .instr       (instr),
    .pc          (pc),
    .fetch_start (fetch_start),
    .fetch_addr  (fetch_addr),
    .data_start  (data_start),
    .rf_we       (rf_we),
    .rf_wdata    (rf_wdata),
    .trap        (trap)
  );

endmodule

`default_nettype wire

//--- tb/riscv_ref_model.svh
`ifndef RISCV_REF_MODEL_SVH
`define RISCV_REF_MODEL_SVH

riscv_pkg::word_t    ref_x [32];
riscv_pkg::word_t    ref_mem [1024];
riscv_pkg::word_t    ref_pc;
riscv_pkg::mem_req_t exp_q [$];
bit                  exp_trap;

function automatic riscv_pkg::word_t alu_calc(input logic [2:0] f3, input bit alt,
                                              input riscv_pkg::word_t a,
                                              input riscv_pkg::word_t b);
  riscv_pkg::word_t r;
  case (f3)
    3'd0: r = alt ? a - b : a + b;
    3'd1: r = a << b[4:0];
    3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: r = (a < b) ? 32'd1 : 32'd0;
    3'd4: r = a ^ b;
    3'd5: begin
      if (alt) r = $signed(a) >>> b[4:0];
      else r = a >> b[4:0];
    end
    3'd6: r = a | b;
    default: r = a & b;
  endcase
  return r;
endfunction

function automatic bit branch_taken(input logic [2:0] f3, input riscv_pkg::word_t a,
                                    input riscv_pkg::word_t b);
  case (f3)
    3'd0: return a == b;
    3'd1: return a != b;
    3'd4: return $signed(a) < $signed(b);
    3'd5: return $signed(a) >= $signed(b);
    3'd6: return a < b;
    default: return a >= b;
  endcase
endfunction

function automatic bit misaligned(input logic [1:0] size, input riscv_pkg::word_t addr);
  return (size == 2'd1 && addr[0]) || (size == 2'd2 && addr[1:0] != 2'b00);
endfunction

// step one instruction and queue its bus transfers
task automatic exec_instr(output bit stop);
  riscv_pkg::word_t ins, a, b, imm, val, npc, addr, w;
  riscv_pkg::strb_t s;
  logic [6:0] op, f7;
  logic [2:0] f3;
  bit wr, jump;
  stop = 0;
  wr = 0;
  jump = 0;
  val = '0;
  exp_q.push_back(riscv_pkg::mem_req_t'{addr: ref_pc, wdata: '0, strb: '0, instr: 1'b1});
  ins = ref_mem[ref_pc[11:2]];
  op = ins[6:0];
  f3 = ins[14:12];
  f7 = ins[31:25];
  a = ref_x[ins[19:15]];
  b = ref_x[ins[24:20]];
  imm = {{20{ins[31]}}, ins[31:20]};
  npc = ref_pc + 32'd4;
  case (op)
    `RV_OP_LUI: begin
      val = {ins[31:12], 12'b0};
      wr = 1;
    end
    `RV_OP_AUIPC: begin
      val = ref_pc + {ins[31:12], 12'b0};
      wr = 1;
    end
    `RV_OP_JAL: begin
      val = npc;
      wr = 1;
      jump = 1;
      npc = ref_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    end
    `RV_OP_JALR: begin
      stop = f3 != 3'd0;
      val = npc;
      wr = 1;
      jump = 1;
      npc = (a + imm) & ~32'd1;
    end
    `RV_OP_BRANCH: begin
      stop = f3[2:1] == 2'b01;
      if (!stop && branch_taken(f3, a, b)) begin
        jump = 1;
        npc = ref_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      end
    end
    `RV_OP_LOAD: begin
      addr = a + imm;
      stop = f3 == 3'd3 || f3 == 3'd6 || f3 == 3'd7 || misaligned(f3[1:0], addr);
      if (!stop) begin
        exp_q.push_back(riscv_pkg::mem_req_t'{addr: addr & ~32'd3, wdata: '0, strb: '0,
                                              instr: 1'b0});
        w = ref_mem[addr[11:2]] >> {addr[1:0], 3'b000};
        case (f3)
          3'd0: val = {{24{w[7]}}, w[7:0]};
          3'd1: val = {{16{w[15]}}, w[15:0]};
          3'd4: val = {24'b0, w[7:0]};
          3'd5: val = {16'b0, w[15:0]};
          default: val = w;
        endcase
        wr = 1;
      end
    end
    `RV_OP_STORE: begin
      addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
      stop = f3 > 3'd2 || misaligned(f3[1:0], addr);
      if (!stop) begin
        case (f3)
          3'd0: begin
            w = {4{b[7:0]}};
            s = 4'b0001 << addr[1:0];
          end
          3'd1: begin
            w = {2{b[15:0]}};
            s = addr[1] ? 4'b1100 : 4'b0011;
          end
          default: begin
            w = b;
            s = 4'b1111;
          end
        endcase
        exp_q.push_back(riscv_pkg::mem_req_t'{addr: addr & ~32'd3, wdata: w, strb: s,
                                              instr: 1'b0});
        for (int i = 0; i < 4; i++) begin
          if (s[i]) ref_mem[addr[11:2]][8*i +: 8] = w[8*i +: 8];
        end
      end
    end
    `RV_OP_IMM: begin
      stop = (f3 == 3'd1 && f7 != 7'h00) ||
             (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
      val = alu_calc(f3, f3 == 3'd5 && ins[30], a, imm);
      wr = 1;
    end
    `RV_OP_REG: begin
      stop = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
      val = alu_calc(f3, ins[30], a, b);
      wr = 1;
    end
    default: stop = 1;
  endcase
  // no compressed set, so targets must be word aligned
  if (jump && npc[1:0] != 2'b00) stop = 1;
  if (!stop) begin
    if (wr && ins[11:7] != 5'd0) ref_x[ins[11:7]] = val;
    ref_pc = npc;
  end
endtask

task automatic run_reference(input int max_steps);
  bit stop;
  for (int i = 0; i < 32; i++) ref_x[i] = '0;
  ref_pc = `RV_RESET_PC;
  exp_q.delete();
  exp_trap = 0;
  for (int n = 0; n < max_steps; n++) begin
    exec_instr(stop);
    if (stop) begin
      exp_trap = 1;
      break;
    end
  end
endtask

`endif

//--- tb/riscv_tb.sv
`default_nettype none

`include "riscv_defs.svh"

module riscv_tb;

  localparam int ROUNDS = 10;
  localparam int NUM_OPS = 40;
  localparam int MAX_INSTR = 200;
  localparam int MAX_WAIT = 4;
  localparam longint LIMIT = longint'(ROUNDS) * (MAX_INSTR * 20 * MAX_WAIT + 60) * 4;

  logic             clk, reset, mem_valid, mem_instr, mem_ready, trap;
  riscv_pkg::word_t mem_addr, mem_wdata, mem_rdata;
  riscv_pkg::strb_t mem_wstrb;

  riscv_pkg::word_t    mem [1024];
  riscv_pkg::mem_req_t got, held;
  bit                  hold_valid;
  int                  wait_cnt;
  int                  code_idx;

  `include "riscv_ref_model.svh"

  riscv_core riscv_core_i (
    .clk       (clk),
    .reset     (reset),
    .mem_valid (mem_valid),
    .mem_instr (mem_instr),
    .mem_ready (mem_ready),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_rdata (mem_rdata),
    .trap      (trap)
  );

  always #2 clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input riscv_pkg::word_t act,
                            input riscv_pkg::word_t exp);
    if (act !== exp)
      abort_run($sformatf("FAIL t=%0t %s expected %h got %h", $time, name, exp, act));
  endtask

  task automatic check_strb(input string name, input riscv_pkg::strb_t act,
                            input riscv_pkg::strb_t exp);
    if (act !== exp)
      abort_run($sformatf("FAIL t=%0t %s expected %b got %b", $time, name, exp, act));
  endtask

  task automatic check_flag(input string name, input logic act, input bit exp);
    if (act !== exp)
      abort_run($sformatf("FAIL t=%0t %s expected %b got %b", $time, name, exp, act));
  endtask

  function automatic riscv_pkg::word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic riscv_pkg::word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OP_STORE};
  endfunction

  function automatic riscv_pkg::word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
  endfunction

  function automatic riscv_pkg::word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
  endfunction

  // offset from x1 into the data region aligned to the access size
  function automatic logic [11:0] data_offset(input logic [1:0] size);
    logic [11:0] off;
    off = 12'(($urandom % 256) * 4);
    if (size == 2'd0) off = off + 12'($urandom % 4);
    else if (size == 2'd1) off = off + 12'(($urandom % 2) * 2);
    return off;
  endfunction

  task automatic place(input riscv_pkg::word_t w);
    mem[code_idx] = w;
    code_idx++;
  endtask

  task automatic build_program(input int round);
    logic [4:0] rd, rs1, rs2, rx;
    logic [2:0] f3;
    logic [6:0] f7;
    bit         writes;
    for (int i = 0; i < 1024; i++) mem[i] = $urandom;
    code_idx = 0;
    // x1 is the data base at 0x400 and is never overwritten
    place(enc_i(12'h400, 5'd0, 3'd0, 5'd1, `RV_OP_IMM));
    repeat (NUM_OPS) begin
      rd = 5'(2 + $urandom % 30);
      rs1 = 5'($urandom);
      rs2 = 5'($urandom);
      f3 = 3'($urandom);
      writes = 1;
      case ($urandom % 8)
        0: begin
          f7 = ($urandom % 2) ? 7'h20 : 7'h00;
          if (f3 == 3'd1) place(enc_i({7'h00, rs2}, rs1, f3, rd, `RV_OP_IMM));
          else if (f3 == 3'd5) place(enc_i({f7, rs2}, rs1, f3, rd, `RV_OP_IMM));
          else place(enc_i(12'($urandom), rs1, f3, rd, `RV_OP_IMM));
        end
        1: begin
          f7 = ((f3 == 3'd0 || f3 == 3'd5) && ($urandom % 2)) ? 7'h20 : 7'h00;
          place({f7, rs2, rs1, f3, rd, `RV_OP_REG});
        end
        2: place({20'($urandom), rd, ($urandom % 2) ? `RV_OP_LUI : `RV_OP_AUIPC});
        3: begin
          f3 = 3'($urandom % 5);
          if (f3 > 3'd2) f3 = f3 + 3'd1;
          place(enc_i(data_offset(f3[1:0]), 5'd1, f3, rd, `RV_OP_LOAD));
        end
        4: begin
          f3 = 3'($urandom % 3);
          place(enc_s(data_offset(f3[1:0]), rs2, 5'd1, f3));
          writes = 0;
        end
        5: begin
          f3 = 3'($urandom % 6);
          if (f3 > 3'd1) f3 = f3 + 3'd2;
          place(enc_b(13'd8, rs2, rs1, f3));
          place(enc_i(12'($urandom), rs1, 3'd0, rd, `RV_OP_IMM));
        end
        6: begin
          // the skipped word keeps its random fill
          place(enc_j(21'd8, rd));
          code_idx++;
        end
        default: begin
          rx = 5'(2 + $urandom % 30);
          place({20'h0, rx, `RV_OP_AUIPC});
          place(enc_i(12'd12, rx, 3'd0, rd, `RV_OP_JALR));
          code_idx++;
        end
      endcase
      if (writes) place(enc_s(data_offset(2'd2), rd, 5'd1, 3'd2));
    end
    case (round % 6)
      0: place(32'hffff_ffff);
      1: place(32'h0000_0073);
      2: place(32'h0010_0073);
      3: place(enc_i(12'd1, 5'd1, 3'd2, 5'd3, `RV_OP_LOAD));
      4: place(enc_s(12'd2, 5'd2, 5'd1, 3'd2));
      default: place(enc_i(12'd2, 5'd1, 3'd0, 5'd5, `RV_OP_JALR));
    endcase
    ref_mem = mem;
  endtask

  // memory responder with a random wait of 0 to 3 cycles
  always @(negedge clk) begin
    if (reset) begin
      mem_ready = 1'b0;
      wait_cnt = $urandom % MAX_WAIT;
    end else if (mem_ready) begin
      mem_ready = 1'b0;
      wait_cnt = $urandom % MAX_WAIT;
    end else if (mem_valid) begin
      if (wait_cnt == 0) begin
        mem_ready = 1'b1;
        mem_rdata = mem[mem_addr[11:2]];
      end else begin
        wait_cnt--;
      end
    end
  end

  // bus monitor
  always @(posedge clk) begin
    if (reset) begin
      hold_valid = 0;
    end else begin
      if (hold_valid) begin
        check_flag("mem_valid", mem_valid, 1'b1);
        check_word("mem_addr", mem_addr, held.addr);
        check_word("mem_wdata", mem_wdata, held.wdata);
        check_strb("mem_wstrb", mem_wstrb, held.strb);
      end
      if (mem_valid && mem_ready) begin
        if (exp_q.size() == 0) abort_run("bus transfer seen where the model expects none");
        got = exp_q.pop_front();
        check_word("mem_addr", mem_addr, got.addr);
        check_flag("mem_instr", mem_instr, got.instr);
        check_strb("mem_wstrb", mem_wstrb, got.strb);
        if (got.strb != '0) check_word("mem_wdata", mem_wdata, got.wdata);
        for (int i = 0; i < 4; i++) begin
          if (mem_wstrb[i]) mem[mem_addr[11:2]][8*i +: 8] = mem_wdata[8*i +: 8];
        end
      end
      hold_valid = mem_valid && !mem_ready;
      held = '{addr: mem_addr, wdata: mem_wdata, strb: mem_wstrb, instr: mem_instr};
    end
  end

  initial begin
    #(LIMIT);
    abort_run("watchdog expired, the core hung or never trapped");
  end

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    mem_ready = 1'b0;
    mem_rdata = '0;
    void'($urandom(32'h8da7));
    for (int round = 0; round < ROUNDS; round++) begin
      @(negedge clk);
      reset = 1'b1;
      build_program(round);
      run_reference(MAX_INSTR);
      if (!exp_trap) abort_run("reference model ran out of steps without a trap");
      repeat (16) @(negedge clk);
      check_flag("mem_valid", mem_valid, 1'b0);
      check_strb("mem_wstrb", mem_wstrb, 4'b0000);
      check_flag("trap", trap, 1'b0);
      reset = 1'b0;
      while (trap !== 1'b1) @(negedge clk);
      // trapped core must stay silent
      repeat (20) begin
        @(negedge clk);
        check_flag("mem_valid", mem_valid, 1'b0);
        check_flag("trap", trap, 1'b1);
      end
      if (exp_q.size() != 0) abort_run("core trapped before all expected transfers");
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+hw
+incdir+tb
hw/riscv_pkg.sv
hw/riscv_decoder.sv
hw/riscv_regfile.sv
hw/riscv_execute.sv
hw/riscv_lsu.sv
hw/riscv_control.sv
hw/riscv_core.sv
tb/riscv_tb.sv

//--- Makefile
TOP       ?= riscv_tb
RTL_TOP   ?= riscv_core
VERILATOR ?= verilator
FLAGS     ?= --timing
OBJ_DIR   ?= obj_dir

RTL_FILES = hw/riscv_pkg.sv hw/riscv_decoder.sv hw/riscv_regfile.sv \
            hw/riscv_execute.sv hw/riscv_lsu.sv hw/riscv_control.sv hw/riscv_core.sv

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) +incdir+hw --top-module $(RTL_TOP) $(RTL_FILES)

sim:
	$(VERILATOR) --binary $(FLAGS) -f all.f --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)
	out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
